//--- common/mem_cmd_if.sv
`timescale 1ns/1ps

interface mem_cmd_if;

logic        start;
logic        write;
logic        ready;       // Low while the memory is busy
logic [31:0] addr;
logic [31:0] wdata;
logic [31:0] wmask;       // Set bits take wdata
logic [31:0] rdata;
logic        rdata_valid; // One cycle after an accepted read

modport stage (
    output start,
    output write,
    output addr,
    output wdata,
    output wmask,
    input  ready,
    input  rdata,
    input  rdata_valid
);

modport ram (
    input  start,
    input  write,
    input  addr,
    input  wdata,
    input  wmask,
    output ready,
    output rdata,
    output rdata_valid
);

endinterface

//--- common/mem_stage_pkg.sv
package mem_stage_pkg;

localparam int MEM_OP_W = 4;
localparam int WB_SEL_W = 4;

// Memory operation codes from execute
localparam logic [MEM_OP_W-1:0] MEN_X       = 4'd0; // No memory access
localparam logic [MEM_OP_W-1:0] MEN_LB      = 4'd1;
localparam logic [MEM_OP_W-1:0] MEN_LBU     = 4'd2;
localparam logic [MEM_OP_W-1:0] MEN_LH      = 4'd3;
localparam logic [MEM_OP_W-1:0] MEN_LHU     = 4'd4;
localparam logic [MEM_OP_W-1:0] MEN_LW      = 4'd5;
localparam logic [MEM_OP_W-1:0] MEN_SB      = 4'd6;
localparam logic [MEM_OP_W-1:0] MEN_SH      = 4'd7;
localparam logic [MEM_OP_W-1:0] MEN_SW      = 4'd8;
localparam logic [MEM_OP_W-1:0] MEN_AMOSWAP = 4'd9; // AMOSWAP.W

localparam logic [WB_SEL_W-1:0] WB_X = 4'd0;

// Bubble record
localparam logic [31:0] INST_NOP  = 32'h0000_0013; // addi x0, x0, 0
localparam logic [31:0] REGPC_NOP = 32'h0000_0000;

// Data memory sizing and timing
localparam int RAM_WORDS       = 256;
localparam int RAM_ADDR_W      = 8;
localparam int RAM_BUSY_CYCLES = 2;
localparam int RAM_BUSY_W      = $clog2(RAM_BUSY_CYCLES + 1);

// Stage FSM encoding
localparam int STATE_W = 2;
localparam logic [STATE_W-1:0] ST_IDLE       = 2'd0;
localparam logic [STATE_W-1:0] ST_WAIT_READY = 2'd1; // Command held until accepted
localparam logic [STATE_W-1:0] ST_WAIT_READ  = 2'd2; // Waiting on rdata_valid

// One data word seen whole, as halfwords or as bytes
typedef union packed {
    logic [31:0]      word;
    logic [1:0][15:0] half;
    logic [3:0][7:0]  bytes;
} mem_word_t;

endpackage

//--- mem_subsystem.f
common/mem_stage_pkg.sv
common/mem_cmd_if.sv
memory_stage/data_ram.sv
memory_stage/memory_stage.sv
verilog/mem_subsystem_top.sv
testbench/memory_stage_properties.sv
testbench/mem_subsystem_tb.sv

//--- memory_stage/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic    clk,
    input  logic    rst_n,
    mem_cmd_if.ram  mem
);

import mem_stage_pkg::*;

logic [31:0]           ram [RAM_WORDS];
logic [RAM_BUSY_W-1:0] busy_cnt;
logic [RAM_ADDR_W-1:0] word_idx;
logic                  accept;
mem_word_t             old_word;
mem_word_t             new_word;

// Byte offset bits are ignored
assign word_idx = mem.addr[RAM_ADDR_W+1:2];

assign mem.ready = busy_cnt == '0;
assign accept    = mem.start && mem.ready;

always_comb begin
    old_word      = ram[word_idx];
    new_word.word = (old_word.word & ~mem.wmask) | (mem.wdata & mem.wmask);
end

// Ready stays low for a fixed time after each accepted command
always_ff @(posedge clk) begin
    if (!rst_n) begin
        busy_cnt <= '0;
    end else if (accept) begin
        busy_cnt <= RAM_BUSY_W'(RAM_BUSY_CYCLES);
    end else if (busy_cnt != '0) begin
        busy_cnt <= busy_cnt - 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        mem.rdata_valid <= 1'b0;
    end else begin
        mem.rdata_valid <= accept && !mem.write; // Single-cycle pulse
    end
end

always_ff @(posedge clk) begin
    if (accept && mem.write) begin
        ram[word_idx] <= new_word.word;
    end
    if (accept && !mem.write) begin
        mem.rdata <= ram[word_idx];
    end
end

endmodule

//--- memory_stage/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,

    input  logic [31:0]                         in_pc,
    input  logic [31:0]                         in_inst,
    input  logic [31:0]                         in_rs2_data,
    input  logic [31:0]                         in_alu_out,
    input  logic [mem_stage_pkg::MEM_OP_W-1:0]  in_mem_op,
    input  logic                                in_rf_wen,
    input  logic [mem_stage_pkg::WB_SEL_W-1:0]  in_wb_sel,
    input  logic [4:0]                          in_wb_addr,

    output logic [31:0]                         wb_read_data,
    output logic [31:0]                         wb_pc,
    output logic [31:0]                         wb_inst,
    output logic [31:0]                         wb_alu_out,
    output logic                                wb_rf_wen,
    output logic [mem_stage_pkg::WB_SEL_W-1:0]  wb_sel,
    output logic [4:0]                          wb_addr,
    output logic                                stall,

    output logic                                hazard_rf_wen,
    output logic [4:0]                          hazard_wb_addr,

    mem_cmd_if.stage                            mem
);

import mem_stage_pkg::*;

function automatic logic op_is_store(input logic [MEM_OP_W-1:0] op);
    return op inside {MEN_SB, MEN_SH, MEN_SW};
endfunction

// AMOSWAP starts out as a read
function automatic logic op_is_load(input logic [MEM_OP_W-1:0] op);
    return op inside {MEN_LB, MEN_LBU, MEN_LH, MEN_LHU, MEN_LW, MEN_AMOSWAP};
endfunction

function automatic logic [31:0] op_wmask(input logic [MEM_OP_W-1:0] op);
    case (op)
        MEN_SB:  return 32'h0000_00ff;
        MEN_SH:  return 32'h0000_ffff;
        default: return 32'hffff_ffff;
    endcase
endfunction

function automatic logic [31:0] load_extend(input logic [MEM_OP_W-1:0] op,
                                            input logic [31:0]         data);
    mem_word_t w;
    w.word = data;
    case (op)
        MEN_LB:              return {{24{w.bytes[0][7]}}, w.bytes[0]};
        MEN_LBU:             return {24'd0, w.bytes[0]};
        MEN_LH:              return {{16{w.half[0][15]}}, w.half[0]};
        MEN_LHU:             return {16'd0, w.half[0]};
        MEN_LW, MEN_AMOSWAP: return w.word;
        default:             return 32'hffff_ffff;
    endcase
endfunction

logic [STATE_W-1:0]  state;
logic [STATE_W-1:0]  state_nxt;
logic [STATE_W-1:0]  eff_state;
logic                is_idle;
logic                done;
logic                amo_rd_done;

// Incoming record after flush squashing
logic [31:0]         live_pc;
logic [31:0]         live_inst;
logic [31:0]         live_rs2;
logic [31:0]         live_alu;
logic [MEM_OP_W-1:0] live_op;
logic                live_rf_wen;
logic [WB_SEL_W-1:0] live_wb_sel;
logic [4:0]          live_wb_addr;
logic                live_store;
logic                live_load;

// Record held while an access is pending
logic [31:0]         sv_pc;
logic [31:0]         sv_inst;
logic [31:0]         sv_rs2;
logic [31:0]         sv_alu;
logic [MEM_OP_W-1:0] sv_op;
logic                sv_rf_wen;
logic [WB_SEL_W-1:0] sv_wb_sel;
logic [4:0]          sv_wb_addr;
logic [31:0]         sv_rdata;     // Old word of a swap
logic                sv_store;

assign live_pc      = flush ? REGPC_NOP     : in_pc;
assign live_inst    = flush ? INST_NOP      : in_inst;
assign live_rs2     = flush ? 32'hffff_ffff : in_rs2_data;
assign live_alu     = flush ? 32'hffff_ffff : in_alu_out;
assign live_op      = flush ? MEN_X         : in_mem_op;
assign live_rf_wen  = flush ? 1'b0          : in_rf_wen;
assign live_wb_sel  = flush ? WB_X          : in_wb_sel;
assign live_wb_addr = flush ? 5'd0          : in_wb_addr;

assign live_store = op_is_store(live_op);
assign live_load  = op_is_load(live_op);
assign sv_store   = op_is_store(sv_op);

// Flush abandons whatever access was pending
assign eff_state = flush ? ST_IDLE : state;
assign is_idle   = eff_state == ST_IDLE;

assign amo_rd_done = (eff_state == ST_WAIT_READ) && mem.rdata_valid && (sv_op == MEN_AMOSWAP);

always_comb begin
    state_nxt = eff_state;
    done      = 1'b0;
    case (eff_state)
        ST_IDLE: begin
            if (live_store) begin
                done      = mem.ready;
                state_nxt = mem.ready ? ST_IDLE : ST_WAIT_READY;
            end else if (live_load) begin
                state_nxt = mem.ready ? ST_WAIT_READ : ST_WAIT_READY;
            end else begin
                done = 1'b1;
            end
        end
        ST_WAIT_READY: begin
            if (mem.ready) begin
                done      = sv_store;
                state_nxt = sv_store ? ST_IDLE : ST_WAIT_READ;
            end
        end
        ST_WAIT_READ: begin
            if (mem.rdata_valid) begin
                done      = !amo_rd_done;
                state_nxt = amo_rd_done ? ST_WAIT_READY : ST_IDLE; // Swap goes on to its write
            end
        end
        default: state_nxt = ST_IDLE;
    endcase
end

assign stall = !done;

// Command comes from the live record in idle, else from the saved copy
assign mem.start = is_idle ? (live_store || live_load) : (eff_state == ST_WAIT_READY);
assign mem.write = is_idle ? live_store : ((eff_state == ST_WAIT_READY) && sv_store);
assign mem.addr  = is_idle ? live_alu : sv_alu;
assign mem.wdata = is_idle ? live_rs2 : sv_rs2;
assign mem.wmask = op_wmask(is_idle ? live_op : sv_op);

assign hazard_rf_wen  = is_idle ? live_rf_wen  : sv_rf_wen;
assign hazard_wb_addr = is_idle ? live_wb_addr : sv_wb_addr;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state <= ST_IDLE;
    end else begin
        state <= state_nxt;
    end
end

always_ff @(posedge clk) begin
    if (is_idle && (state_nxt != ST_IDLE)) begin
        sv_pc      <= live_pc;
        sv_inst    <= live_inst;
        sv_rs2     <= live_rs2;
        sv_alu     <= live_alu;
        sv_op      <= live_op;
        sv_rf_wen  <= live_rf_wen;
        sv_wb_sel  <= live_wb_sel;
        sv_wb_addr <= live_wb_addr;
        sv_rdata   <= 32'hffff_ffff;
    end else if (amo_rd_done) begin
        sv_op    <= MEN_SW;     // rs2 written to the same word
        sv_rdata <= mem.rdata;
    end
end

always_ff @(posedge clk) begin
    if (!rst_n || !done) begin
        wb_read_data <= 32'hffff_ffff;
        wb_pc        <= REGPC_NOP;
        wb_inst      <= INST_NOP;
        wb_alu_out   <= 32'hffff_ffff;
        wb_rf_wen    <= 1'b0;
        wb_sel       <= WB_X;
        wb_addr      <= 5'd0;
    end else if (is_idle) begin
        wb_read_data <= 32'hffff_ffff; // Never a load here
        wb_pc        <= live_pc;
        wb_inst      <= live_inst;
        wb_alu_out   <= live_alu;
        wb_rf_wen    <= live_rf_wen;
        wb_sel       <= live_wb_sel;
        wb_addr      <= live_wb_addr;
    end else begin
        wb_read_data <= (eff_state == ST_WAIT_READ) ? load_extend(sv_op, mem.rdata) : sv_rdata;
        wb_pc        <= sv_pc;
        wb_inst      <= sv_inst;
        wb_alu_out   <= sv_alu;
        wb_rf_wen    <= sv_rf_wen;
        wb_sel       <= sv_wb_sel;
        wb_addr      <= sv_wb_addr;
    end
end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; status follows the testbench verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f mem_subsystem.f --top-module mem_subsystem_tb -o mem_subsystem_sim &&
./obj_dir/mem_subsystem_sim | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- testbench/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb;

import mem_stage_pkg::*;

localparam int NUM_ENTRIES  = 21;
localparam int NUM_TESTS    = 6;
localparam int RESET_CYCLES = 10;
localparam int CYCLE_LIMIT  = NUM_ENTRIES * 12 + RESET_CYCLES + 50;

typedef struct packed {
    int                  test;
    logic [MEM_OP_W-1:0] op;
    logic [31:0]         addr;
    logic [31:0]         rs2;
    logic                rf_wen;
    logic [WB_SEL_W-1:0] sel;
    logic [4:0]          wb_addr;
    logic                flush;
    logic [31:0]         exp_rdata;
} stim_t;

typedef struct packed {
    int                  test;
    logic [31:0]         inst;
    logic [31:0]         pc;
    logic [31:0]         alu;
    logic                rf_wen;
    logic [WB_SEL_W-1:0] sel;
    logic [4:0]          wb_addr;
    logic [31:0]         rdata;
} exp_t;

logic                clk;
logic                rst_n;
logic                flush;
logic [31:0]         in_pc;
logic [31:0]         in_inst;
logic [31:0]         in_rs2_data;
logic [31:0]         in_alu_out;
logic [MEM_OP_W-1:0] in_mem_op;
logic                in_rf_wen;
logic [WB_SEL_W-1:0] in_wb_sel;
logic [4:0]          in_wb_addr;
logic [31:0]         wb_read_data;
logic [31:0]         wb_pc;
logic [31:0]         wb_inst;
logic [31:0]         wb_alu_out;
logic                wb_rf_wen;
logic [WB_SEL_W-1:0] wb_sel;
logic [4:0]          wb_addr;
logic                stall;
logic                hazard_rf_wen;
logic [4:0]          hazard_wb_addr;

stim_t       stim [NUM_ENTRIES];
exp_t        exp_q [$];
exp_t        cur;
logic [31:0] shadow [RAM_WORDS]; // Reference copy of data memory
string       test_name [NUM_TESTS];
int          test_checks [NUM_TESTS];
int          test_errors [NUM_TESTS];
int          err_count;
int          total_checks;
int          cycle_cnt;

mem_subsystem_top mem_subsystem_top_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .in_pc          (in_pc),
    .in_inst        (in_inst),
    .in_rs2_data    (in_rs2_data),
    .in_alu_out     (in_alu_out),
    .in_mem_op      (in_mem_op),
    .in_rf_wen      (in_rf_wen),
    .in_wb_sel      (in_wb_sel),
    .in_wb_addr     (in_wb_addr),
    .wb_read_data   (wb_read_data),
    .wb_pc          (wb_pc),
    .wb_inst        (wb_inst),
    .wb_alu_out     (wb_alu_out),
    .wb_rf_wen      (wb_rf_wen),
    .wb_sel         (wb_sel),
    .wb_addr        (wb_addr),
    .stall          (stall),
    .hazard_rf_wen  (hazard_rf_wen),
    .hazard_wb_addr (hazard_wb_addr)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// Unique tags so each record can be told apart from a bubble
function automatic logic [31:0] inst_of(input int idx);
    return 32'h0000_1000 + idx * 32'h100;
endfunction

function automatic logic [31:0] pc_of(input int idx);
    return 32'h0000_4000 + idx * 4;
endfunction

function automatic logic [RAM_ADDR_W-1:0] word_index(input logic [31:0] addr);
    return addr[RAM_ADDR_W+1:2];
endfunction

function automatic logic [31:0] model_load(input logic [MEM_OP_W-1:0] op,
                                           input logic [31:0]         addr);
    logic [31:0] w;
    w = shadow[word_index(addr)];
    case (op)
        MEN_LB:  return 32'($signed(w[7:0]));
        MEN_LBU: return 32'(w[7:0]);
        MEN_LH:  return 32'($signed(w[15:0]));
        MEN_LHU: return 32'(w[15:0]);
        default: return w;
    endcase
endfunction

// Subword stores land in the low lanes
function automatic void model_store(input logic [MEM_OP_W-1:0] op,
                                    input logic [31:0]         addr,
                                    input logic [31:0]         data);
    case (op)
        MEN_SB:  shadow[word_index(addr)][7:0]  = data[7:0];
        MEN_SH:  shadow[word_index(addr)][15:0] = data[15:0];
        default: shadow[word_index(addr)]       = data;
    endcase
endfunction

task automatic record_error(input int t);
    err_count++;
    test_errors[t]++;
endtask

task automatic drive_idle();
    flush       <= 1'b0;
    in_pc       <= REGPC_NOP;
    in_inst     <= INST_NOP;
    in_rs2_data <= 32'd0;
    in_alu_out  <= 32'd0;
    in_mem_op   <= MEN_X;
    in_rf_wen   <= 1'b0;
    in_wb_sel   <= WB_X;
    in_wb_addr  <= 5'd0;
endtask

task automatic load_table();
    //          test op           addr     rs2            rf_wen sel   wb     flush exp_rdata
    stim[0]  = '{1, MEN_SW,      32'h040, 32'h1122_3344, 1'b0, 4'd0, 5'd0,  1'b0, 32'hffff_ffff};
    stim[1]  = '{1, MEN_SH,      32'h040, 32'haaaa_5566, 1'b0, 4'd0, 5'd0,  1'b0, 32'hffff_ffff};
    stim[2]  = '{1, MEN_SB,      32'h040, 32'hbbbb_bb77, 1'b0, 4'd0, 5'd0,  1'b0, 32'hffff_ffff};
    stim[3]  = '{1, MEN_LW,      32'h040, 32'h0000_0000, 1'b1, 4'd1, 5'd5,  1'b0, 32'h1122_5577};
    stim[4]  = '{2, MEN_SW,      32'h080, 32'h1234_f0a5, 1'b0, 4'd0, 5'd0,  1'b0, 32'hffff_ffff};
    stim[5]  = '{2, MEN_LB,      32'h080, 32'h0000_0000, 1'b1, 4'd1, 5'd6,  1'b0, 32'hffff_ffa5};
    stim[6]  = '{2, MEN_LBU,     32'h080, 32'h0000_0000, 1'b1, 4'd1, 5'd7,  1'b0, 32'h0000_00a5};
    stim[7]  = '{2, MEN_LH,      32'h080, 32'h0000_0000, 1'b1, 4'd1, 5'd8,  1'b0, 32'hffff_f0a5};
    stim[8]  = '{2, MEN_LHU,     32'h080, 32'h0000_0000, 1'b1, 4'd1, 5'd9,  1'b0, 32'h0000_f0a5};
    stim[9]  = '{3, MEN_X,       32'hdead_beef, 32'h0, 1'b1, 4'd2, 5'd10, 1'b0, 32'hffff_ffff};
    stim[10] = '{3, MEN_SW,      32'h0c0, 32'h0bad_f00d, 1'b0, 4'd0, 5'd0,  1'b0, 32'hffff_ffff};
    stim[11] = '{3, MEN_SW,      32'h0c4, 32'h5555_aaaa, 1'b0, 4'd0, 5'd0,  1'b0, 32'hffff_ffff};
    stim[12] = '{3, MEN_LW,      32'h0c0, 32'h0000_0000, 1'b1, 4'd1, 5'd11, 1'b0, 32'h0bad_f00d};
    stim[13] = '{3, MEN_LW,      32'h0c4, 32'h0000_0000, 1'b1, 4'd1, 5'd12, 1'b0, 32'h5555_aaaa};
    stim[14] = '{3, MEN_X,       32'h042, 32'h0000_0000, 1'b0, 4'd3, 5'd13, 1'b0, 32'hffff_ffff};
    stim[15] = '{4, MEN_SW,      32'h100, 32'hcafe_0001, 1'b0, 4'd0, 5'd0,  1'b0, 32'hffff_ffff};
    stim[16] = '{4, MEN_AMOSWAP, 32'h100, 32'h600d_cafe, 1'b1, 4'd1, 5'd14, 1'b0, 32'hcafe_0001};
    stim[17] = '{4, MEN_LW,      32'h100, 32'h0000_0000, 1'b1, 4'd1, 5'd15, 1'b0, 32'h600d_cafe};
    stim[18] = '{5, MEN_SW,      32'h140, 32'h7777_0000, 1'b0, 4'd0, 5'd0,  1'b0, 32'hffff_ffff};
    stim[19] = '{5, MEN_SW,      32'h140, 32'h9999_9999, 1'b0, 4'd0, 5'd0,  1'b1, 32'hffff_ffff};
    stim[20] = '{5, MEN_LW,      32'h140, 32'h0000_0000, 1'b1, 4'd1, 5'd16, 1'b0, 32'h7777_0000};
endtask

// Drive one entry and hold it until the stage takes it
task automatic present_entry(input int idx);
    stim_t       e;
    exp_t        x;
    logic [31:0] rdata;
    e = stim[idx];
    @(posedge clk);
    flush       <= e.flush;
    in_pc       <= pc_of(idx);
    in_inst     <= inst_of(idx);
    in_rs2_data <= e.rs2;
    in_alu_out  <= e.addr;
    in_mem_op   <= e.op;
    in_rf_wen   <= e.rf_wen;
    in_wb_sel   <= e.sel;
    in_wb_addr  <= e.wb_addr;
    if (!e.flush) begin
        rdata = 32'hffff_ffff; // Stores and non-memory records
        if (e.op inside {MEN_LB, MEN_LBU, MEN_LH, MEN_LHU, MEN_LW, MEN_AMOSWAP}) begin
            rdata = model_load(e.op, e.addr);
        end
        if (e.op inside {MEN_SB, MEN_SH, MEN_SW, MEN_AMOSWAP}) begin
            model_store(e.op, e.addr, e.rs2);
        end
        assert (rdata == e.exp_rdata) else begin
            $display("Fail %0t: table entry %0d expects %h but the memory model gives %h",
                     $time, idx, e.exp_rdata, rdata);
            record_error(e.test);
        end
        x.test    = e.test;
        x.inst    = inst_of(idx);
        x.pc      = pc_of(idx);
        x.alu     = e.addr;
        x.rf_wen  = e.rf_wen;
        x.sel     = e.sel;
        x.wb_addr = e.wb_addr;
        x.rdata   = rdata;
        exp_q.push_back(x);
    end
    @(negedge clk);
    while (stall) begin
        test_checks[e.test]++;
        assert (hazard_wb_addr == e.wb_addr && hazard_rf_wen == e.rf_wen) else begin
            $display("Fail %0t: hazard shows x%0d rf_wen %b while entry %0d for x%0d stalls",
                     $time, hazard_wb_addr, hazard_rf_wen, idx, e.wb_addr);
            record_error(e.test);
        end
        @(negedge clk);
    end
endtask

task automatic report_test(input int t);
    $display("Test %0d %s: %0d checks, %0d errors", t, test_name[t], test_checks[t],
             test_errors[t]);
endtask

// Every record that is not a bubble must match the next expected one
always @(negedge clk) begin
    if (rst_n && wb_inst != INST_NOP) begin
        assert (exp_q.size() != 0) else begin
            $display("Writeback record with inst %h appeared at %0t with none expected",
                     wb_inst, $time);
            err_count++;
        end
        if (exp_q.size() != 0) begin
            cur = exp_q.pop_front();
            test_checks[cur.test]++;
            assert (wb_inst == cur.inst && wb_pc == cur.pc && wb_alu_out == cur.alu &&
                    wb_rf_wen == cur.rf_wen && wb_sel == cur.sel &&
                    wb_addr == cur.wb_addr) else begin
                $display("Fail %0t: inst %h pc %h alu %h rf_wen %b sel %0d addr %0d, expected %h",
                         $time, wb_inst, wb_pc, wb_alu_out, wb_rf_wen, wb_sel, wb_addr,
                         cur.inst);
                record_error(cur.test);
            end
            assert (wb_read_data == cur.rdata) else begin
                $display("Fail %0t: inst %h read data %h, expected %h",
                         $time, wb_inst, wb_read_data, cur.rdata);
                record_error(cur.test);
            end
        end
    end
end

initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
        @(posedge clk);
        cycle_cnt++;
    end
    $display("Timeout: run still busy after %0d cycles", CYCLE_LIMIT);
    $display("ERRORS FOUND");
    $finish;
end

initial begin
    int t;
    int i;
    rst_n     = 1'b0;
    err_count = 0;
    drive_idle();
    test_name[0] = "reset";
    test_name[1] = "stores by width";
    test_name[2] = "load extension";
    test_name[3] = "pass-through and back-to-back";
    test_name[4] = "amoswap";
    test_name[5] = "flush";
    for (t = 0; t < NUM_TESTS; t++) begin
        test_checks[t] = 0;
        test_errors[t] = 0;
    end
    load_table();

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    test_checks[0]++;
    assert (wb_rf_wen == 1'b0 && wb_inst == INST_NOP && stall == 1'b0) else begin
        $display("Fail %0t: after reset rf_wen %b inst %h stall %b",
                 $time, wb_rf_wen, wb_inst, stall);
        record_error(0);
    end
    report_test(0);

    for (t = 1; t < NUM_TESTS; t++) begin
        for (i = 0; i < NUM_ENTRIES; i++) begin
            if (stim[i].test == t) begin
                present_entry(i);
            end
        end
        @(posedge clk);
        drive_idle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        report_test(t);
    end

    total_checks = 0;
    for (t = 0; t < NUM_TESTS; t++) begin
        total_checks += test_checks[t];
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, total_checks, err_count);
    if (err_count == 0) begin
        $display("NO ERRORS");
    end else begin
        $display("ERRORS FOUND");
    end
    $finish;
end

endmodule

//--- testbench/memory_stage_properties.sv
`timescale 1ns/1ps

module memory_stage_properties (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic write,
    input logic ready,
    input logic rdata_valid
);

logic read_accept;

assign read_accept = start && ready && !write; // Read handed to memory

read_returns: assert property (@(posedge clk) disable iff (!rst_n)
    read_accept |=> rdata_valid)
    else $error("Accepted read not followed by rdata_valid");

write_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
    write |-> start)
    else $error("write high without start");

// No stray read data
valid_has_read: assert property (@(posedge clk) disable iff (!rst_n)
    rdata_valid |-> $past(read_accept))
    else $error("rdata_valid without a read accepted one cycle before");

endmodule

bind memory_stage memory_stage_properties memory_stage_properties_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (mem.start),
    .write       (mem.write),
    .ready       (mem.ready),
    .rdata_valid (mem.rdata_valid)
);

//--- verilog/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,

    input  logic [31:0]                         in_pc,
    input  logic [31:0]                         in_inst,
    input  logic [31:0]                         in_rs2_data,
    input  logic [31:0]                         in_alu_out,
    input  logic [mem_stage_pkg::MEM_OP_W-1:0]  in_mem_op,
    input  logic                                in_rf_wen,
    input  logic [mem_stage_pkg::WB_SEL_W-1:0]  in_wb_sel,
    input  logic [4:0]                          in_wb_addr,

    output logic [31:0]                         wb_read_data,
    output logic [31:0]                         wb_pc,
    output logic [31:0]                         wb_inst,
    output logic [31:0]                         wb_alu_out,
    output logic                                wb_rf_wen,
    output logic [mem_stage_pkg::WB_SEL_W-1:0]  wb_sel,
    output logic [4:0]                          wb_addr,
    output logic                                stall,

    output logic                                hazard_rf_wen,
    output logic [4:0]                          hazard_wb_addr
);

mem_cmd_if mem_bus ();

memory_stage memory_stage_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .in_pc          (in_pc),
    .in_inst        (in_inst),
    .in_rs2_data    (in_rs2_data),
    .in_alu_out     (in_alu_out),
    .in_mem_op      (in_mem_op),
    .in_rf_wen      (in_rf_wen),
    .in_wb_sel      (in_wb_sel),
    .in_wb_addr     (in_wb_addr),
    .wb_read_data   (wb_read_data),
    .wb_pc          (wb_pc),
    .wb_inst        (wb_inst),
    .wb_alu_out     (wb_alu_out),
    .wb_rf_wen      (wb_rf_wen),
    .wb_sel         (wb_sel),
    .wb_addr        (wb_addr),
    .stall          (stall),
    .hazard_rf_wen  (hazard_rf_wen),
    .hazard_wb_addr (hazard_wb_addr),
    .mem            (mem_bus.stage)
);

data_ram data_ram_i (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (mem_bus.ram)
);

endmodule
